//--- design/pattern_pkg.sv
package pattern_pkg;

	//////////////////////////////
	// widths
	typedef logic [31:0] phase_t;     // one full turn per wrap
	typedef logic [9:0]  lut_addr_t;  // top phase bits
	typedef logic [7:0]  pixel_t;     // intensity byte
	typedef logic [5:0]  frame_t;

	//////////////////////////////
	// calibration sequence
	localparam int FRAME_COUNT      = 28;
	localparam int FRINGE_FRAMES    = 24;  // first flat frame
	localparam int PHASE_STEPS      = 8;   // steps per frequency group
	localparam int PROJ1_STEP_SHIFT = 29;  // eighth turn per step
	localparam int PROJ2_STEP_SHIFT = 30;  // quarter turn per step

	// 2^32/648, 2^32/108, 2^32/18 per line
	localparam phase_t PHASE_INC_TABLE [3] = '{32'd6628036, 32'd39768216, 32'd238609294};

	typedef struct packed {
		phase_t inc;     // added once per active line
		phase_t offset;  // phase of active line 0
	} phase_cfg_t;

	typedef struct packed {
		phase_cfg_t proj1;
		phase_cfg_t proj2;
	} dual_phase_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
		logic line_end;   // last clock of a line
		logic frame_end;  // last clock of the last line
	} timing_strobes_t;

	// start delay before the projector trigger is let through
	typedef enum logic [1:0] {WAIT_ENABLE, ARMED, RUNNING} seq_state_t;

	function automatic lut_addr_t lut_index(phase_t phase);
		return phase[$bits(phase_t)-1 -: $bits(lut_addr_t)];
	endfunction

	// fringe frames: group picks the increment, step sets the offset
	function automatic phase_cfg_t phase_rule(frame_t frame, int step_shift);
		phase_cfg_t cfg;
		int         step;
		int         group;
		step  = int'(frame) % PHASE_STEPS;
		group = int'(frame) / PHASE_STEPS;
		if (int'(frame) >= FRINGE_FRAMES) begin
			cfg.inc    = '0;                 // flat frame
			cfg.offset = {frame[0], 31'd0};  // half turn on odd frames
		end else begin
			cfg.inc    = PHASE_INC_TABLE[group];
			cfg.offset = phase_t'(step) << step_shift;
		end
		return cfg;
	endfunction

	function automatic phase_cfg_t proj1_rule(frame_t frame);
		return phase_rule(frame, PROJ1_STEP_SHIFT);
	endfunction

	function automatic phase_cfg_t proj2_rule(frame_t frame);
		return phase_rule(frame, PROJ2_STEP_SHIFT);
	endfunction

endpackage

//--- design/video_timing.sv
`timescale 1ns/10ps

module video_timing import pattern_pkg::*; #(
	parameter int H_ACTIVE = 16,
	parameter int H_TOTAL  = 24,
	parameter int V_ACTIVE = 8,
	parameter int V_TOTAL  = 12
) (
	input  logic            CLK_50M,
	input  logic            reset,
	output timing_strobes_t timing,
	output logic [9:0]      line_index  // active line number, 0 in blanking
);
	localparam int H_W      = $clog2(H_TOTAL);
	localparam int V_W      = $clog2(V_TOTAL);
	localparam int V_BLANK  = V_TOTAL - V_ACTIVE;  // blank rows lead the frame
	localparam int HS_START = H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4;
	localparam int HS_STOP  = H_ACTIVE + (H_TOTAL - H_ACTIVE) * 3 / 4;

	logic [H_W-1:0]  h_cnt;  // column
	logic [V_W-1:0]  v_cnt;  // row
	logic            h_last;
	logic            v_last;
	logic            v_active;
	timing_strobes_t strobes_next;

	assign h_last   = (h_cnt == H_W'(H_TOTAL - 1));
	assign v_last   = (v_cnt == V_W'(V_TOTAL - 1));
	assign v_active = (v_cnt >= V_W'(V_BLANK));

	//////////////////////////////
	// free running counters
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			h_cnt <= h_last ? '0 : h_cnt + 1'b1;
			if (h_last)
				v_cnt <= v_last ? '0 : v_cnt + 1'b1;
		end
	end

	// strobe decode, registered below so all bits line up
	always_comb begin
		strobes_next.hsync     = (h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_STOP));
		strobes_next.vsync     = (v_cnt == '0);  // first blank row
		strobes_next.de        = (h_cnt < H_W'(H_ACTIVE)) && v_active;
		strobes_next.line_end  = h_last;
		strobes_next.frame_end = h_last && v_last;
	end

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			timing     <= '0;
			line_index <= '0;
		end else begin
			timing     <= strobes_next;
			line_index <= v_active ? 10'(v_cnt - V_W'(V_BLANK)) : 10'd0;
		end
	end

endmodule

//--- design/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer import pattern_pkg::*; (
	input  logic            CLK_50M,
	input  logic            reset,
	input  timing_strobes_t timing,
	input  logic            sync_in_1,    // low parks at the last frame
	input  logic            sync_in_2,    // high lets frames advance
	output frame_t          frame_index,
	output logic            frame_start,  // one clock, with the frame update
	output logic            sync_out_1,
	output logic            sync_out_2
);
	localparam frame_t LAST_FRAME = frame_t'(FRAME_COUNT - 1);

	seq_state_t state;
	seq_state_t state_next;
	frame_t     frame_next;
	logic       advance;

	assign advance = timing.frame_end && sync_in_1 && sync_in_2;

	//////////////////////////////
	// next frame and start delay
	always_comb begin
		frame_next = frame_index;
		state_next = state;
		if (!sync_in_1) begin
			frame_next = LAST_FRAME;  // next advance lands on frame 0
			state_next = WAIT_ENABLE;
		end else if (timing.frame_end) begin
			if (!sync_in_2) begin
				state_next = WAIT_ENABLE;  // hold, restart the delay
			end else begin
				frame_next = (frame_index == LAST_FRAME) ? '0 : frame_index + 1'b1;
				case (state)
					WAIT_ENABLE: state_next = ARMED;
					ARMED:       state_next = RUNNING;
					default:     state_next = RUNNING;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			frame_index <= LAST_FRAME;
			state       <= WAIT_ENABLE;
			frame_start <= 1'b0;
			sync_out_2  <= 1'b0;
		end else begin
			frame_index <= frame_next;
			state       <= state_next;
			frame_start <= advance;
			sync_out_2  <= ((int'(frame_next) % PHASE_STEPS) == 1);  // step 1 trigger
		end
	end

	// camera trigger only once the delay has run out
	assign sync_out_1 = timing.vsync && (state == RUNNING);

endmodule

//--- design/phase_planner.sv
`timescale 1ns/10ps

module phase_planner import pattern_pkg::*; (
	input  logic            CLK_50M,
	input  logic            reset,
	input  frame_t          frame_index,
	input  logic            frame_start,
	output dual_phase_cfg_t cfg
);
	dual_phase_cfg_t cfg_next;

	//////////////////////////////
	// per frame phase rules
	always_comb begin
		cfg_next.proj1 = proj1_rule(frame_index);  // eighth turn steps
		cfg_next.proj2 = proj2_rule(frame_index);  // quarter turn steps
	end

	// held for the whole frame, accumulators pick it up in the blank rows
	always_ff @(posedge CLK_50M) begin
		if (reset)
			cfg <= '0;
		else if (frame_start)
			cfg <= cfg_next;
	end

endmodule

//--- design/phase_accumulator.sv
`timescale 1ns/10ps

module phase_accumulator import pattern_pkg::*; (
	input  logic            CLK_50M,
	input  logic            reset,
	input  phase_cfg_t      cfg,
	input  timing_strobes_t timing,
	input  logic            first_line,  // row index still zero
	output phase_t          phase
);
	logic line_active;  // de seen on the current line
	logic active_now;

	assign active_now = line_active || timing.de;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			phase       <= '0;
			line_active <= 1'b0;
		end else if (timing.line_end) begin
			line_active <= 1'b0;
			if (active_now)
				phase <= phase + cfg.inc;  // step to the next row
			else if (first_line)
				phase <= cfg.offset;       // blank rows preload the new frame
		end else if (timing.de) begin
			line_active <= 1'b1;
		end
	end

endmodule

//--- design/fringe_lut.sv
`timescale 1ns/10ps

module fringe_lut import pattern_pkg::*; (
	input  logic   CLK_50M,
	input  logic   reset,
	input  pixel_t rx_byte,
	input  logic   rx_strobe,  // one clock per byte
	input  phase_t phase_1,
	input  phase_t phase_2,
	output pixel_t pixel_1,
	output pixel_t pixel_2,
	output pixel_t led         // copy of the last entry
);
	localparam int        ADDR_W    = $bits(lut_addr_t);
	localparam int        LUT_DEPTH = 2 ** ADDR_W;
	localparam lut_addr_t LED_ENTRY = lut_addr_t'(LUT_DEPTH - 1);

	pixel_t        lut_mem [LUT_DEPTH];
	logic [ADDR_W:0] load_addr;  // msb set once the table is full
	lut_addr_t     wr_addr;
	logic          load_en;

	assign wr_addr = load_addr[ADDR_W-1:0];
	assign load_en = rx_strobe && !load_addr[ADDR_W];  // extra bytes dropped

	//////////////////////////////
	// byte load
	always_ff @(posedge CLK_50M) begin
		if (reset)
			load_addr <= '0;
		else if (load_en)
			load_addr <= load_addr + 1'b1;
	end

	always_ff @(posedge CLK_50M) begin
		if (load_en)
			lut_mem[wr_addr] <= rx_byte;
	end

	// led shadow, tracks writes to the top entry
	always_ff @(posedge CLK_50M) begin
		if (reset)
			led <= '0;
		else if (load_en && (wr_addr == LED_ENTRY))
			led <= rx_byte;
	end

	//////////////////////////////
	// two registered read ports
	always_ff @(posedge CLK_50M) begin
		pixel_1 <= lut_mem[lut_index(phase_1)];
		pixel_2 <= lut_mem[lut_index(phase_2)];
	end

endmodule

//--- design/pattern_top.sv
`timescale 1ns/10ps

module pattern_top import pattern_pkg::*; #(
	parameter int H_ACTIVE = 16,
	parameter int H_TOTAL  = 24,
	parameter int V_ACTIVE = 8,
	parameter int V_TOTAL  = 12
) (
	input  logic            CLK_50M,
	input  logic            reset,
	input  pixel_t          rx_byte,
	input  logic            rx_strobe,
	input  logic            sync_in_1,
	input  logic            sync_in_2,
	output pixel_t          pixel_1,
	output pixel_t          pixel_2,
	output timing_strobes_t video,  // aligned with the pixels
	output logic            sync_out_1,
	output logic            sync_out_2,
	output frame_t          frame_index,
	output pixel_t          led
);
	timing_strobes_t timing;
	logic [9:0]      line_index;
	logic            first_line;
	logic            frame_start;
	dual_phase_cfg_t cfg;
	phase_t          phase_1;
	phase_t          phase_2;

	assign first_line = (line_index == '0);

	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) timing_gen (
		.CLK_50M(CLK_50M), .reset(reset), .timing(timing), .line_index(line_index)
	);

	frame_sequencer sequencer (
		.CLK_50M(CLK_50M), .reset(reset), .timing(timing),
		.sync_in_1(sync_in_1), .sync_in_2(sync_in_2),
		.frame_index(frame_index), .frame_start(frame_start),
		.sync_out_1(sync_out_1), .sync_out_2(sync_out_2)
	);

	phase_planner planner (
		.CLK_50M(CLK_50M), .reset(reset), .frame_index(frame_index),
		.frame_start(frame_start), .cfg(cfg)
	);

	//////////////////////////////
	// one accumulator per projector
	phase_accumulator proj1_acc (
		.CLK_50M(CLK_50M), .reset(reset), .cfg(cfg.proj1), .timing(timing),
		.first_line(first_line), .phase(phase_1)
	);

	phase_accumulator proj2_acc (
		.CLK_50M(CLK_50M), .reset(reset), .cfg(cfg.proj2), .timing(timing),
		.first_line(first_line), .phase(phase_2)
	);

	fringe_lut lut (
		.CLK_50M(CLK_50M), .reset(reset), .rx_byte(rx_byte), .rx_strobe(rx_strobe),
		.phase_1(phase_1), .phase_2(phase_2),
		.pixel_1(pixel_1), .pixel_2(pixel_2), .led(led)
	);

	// match the lut read latency
	always_ff @(posedge CLK_50M) begin
		if (reset)
			video <= '0;
		else
			video <= timing;
	end

endmodule

//--- sim/pattern_sva.sv
`timescale 1ns/10ps

module pattern_sva import pattern_pkg::*; (
	input logic            CLK_50M,
	input logic            reset,
	input logic            sync_in_1,
	input logic            sync_in_2,
	input logic            sync_out_1,
	input logic            sync_out_2,
	input frame_t          frame_index,
	input pixel_t          pixel_1,
	input pixel_t          pixel_2,
	input timing_strobes_t timing,
	input timing_strobes_t video
);
	logic [1:0] advances;        // frame advances since the last stop up to 2
	logic       hsync_seen;      // horizontal sync in the current output line
	int         fail_count = 0;  // failed assertions so far

	always_ff @(posedge CLK_50M) begin
		if (reset || !sync_in_1)
			advances <= '0;
		else if (timing.frame_end)
			advances <= !sync_in_2 ? 2'd0 : (advances == 2'd2) ? advances : advances + 1'b1;
	end

	always_ff @(posedge CLK_50M) begin
		if (reset || video.line_end)
			hsync_seen <= 1'b0;
		else if (video.hsync)
			hsync_seen <= 1'b1;
	end

	//////////////////////////////
	// frame sequencing
	frame_step: assert property (@(posedge CLK_50M) disable iff (reset)
		$changed(frame_index) && $past(sync_in_1)
		|-> frame_index == frame_t'((int'($past(frame_index)) + 1) % FRAME_COUNT))
		else begin
			$error("frame_index did not step by one");
			fail_count++;
		end

	frame_park: assert property (@(posedge CLK_50M) disable iff (reset)
		!$past(sync_in_1) |-> frame_index == frame_t'(FRAME_COUNT - 1))
		else begin
			$error("frame_index not parked at the last frame");
			fail_count++;
		end

	//////////////////////////////
	// projector triggers
	trigger_1: assert property (@(posedge CLK_50M) disable iff (reset)
		sync_out_1 == (timing.vsync && advances == 2'd2))
		else begin
			$error("sync_out_1 does not follow the start delay");
			fail_count++;
		end

	trigger_2: assert property (@(posedge CLK_50M) disable iff (reset)
		sync_out_2 == ((int'(frame_index) % PHASE_STEPS) == 1))
		else begin
			$error("sync_out_2 wrong for the current frame");
			fail_count++;
		end

	//////////////////////////////
	// output video
	// one lut entry per line
	line_flat: assert property (@(posedge CLK_50M) disable iff (reset)
		video.de && $past(video.de) |-> $stable(pixel_1) && $stable(pixel_2))
		else begin
			$error("pixel changed inside a line");
			fail_count++;
		end

	hsync_line: assert property (@(posedge CLK_50M) disable iff (reset)
		video.line_end |-> hsync_seen)
		else begin
			$error("no hsync pulse in the line");
			fail_count++;
		end

	hsync_blank: assert property (@(posedge CLK_50M) disable iff (reset)
		video.hsync |-> !video.de)
		else begin
			$error("hsync high during active pixels");
			fail_count++;
		end

endmodule

bind pattern_top pattern_sva sva0 (
	.CLK_50M(CLK_50M), .reset(reset), .sync_in_1(sync_in_1), .sync_in_2(sync_in_2),
	.sync_out_1(sync_out_1), .sync_out_2(sync_out_2), .frame_index(frame_index),
	.pixel_1(pixel_1), .pixel_2(pixel_2), .timing(timing), .video(video)
);

//--- sim/tb_pattern.sv
`timescale 1ns/10ps

module tb_pattern import pattern_pkg::*; ();

	localparam int H_ACTIVE   = 16;
	localparam int H_TOTAL    = 24;
	localparam int V_ACTIVE   = 8;
	localparam int V_TOTAL    = 12;
	localparam int V_BLANK    = V_TOTAL - V_ACTIVE;  // blank rows lead each frame
	localparam int LOAD_BYTES = 1030;                // six past the table end
	localparam int TEST_COUNT = 5;
	// a full sequence per test plus a margin for the lut load
	localparam int TIMEOUT_NS = TEST_COUNT * FRAME_COUNT * H_TOTAL * V_TOTAL * 20 + 50000;
	localparam int LINE_PERIOD [3] = '{648, 108, 18};  // lines per fringe in each group

	logic            CLK_50M, reset, rx_strobe, sync_in_1, sync_in_2, sync_out_1, sync_out_2;
	pixel_t          rx_byte, pixel_1, pixel_2, led;
	timing_strobes_t video;
	frame_t          frame_index;

	pixel_t lut_copy [1024];    // bytes as sent
	integer seed         = 63;
	int     errors       = 0;
	int     errors_seen  = 0;   // count at the last test report
	int     tests        = 0;
	int     row          = 0;   // output row counting blank rows
	int     col          = 0;   // output column counted from the line end
	logic   check_pixels = 1'b0;

	pattern_top #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) dut0 (.*);

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;  // 50 MHz
	end

	//////////////////////////////
	// reference model and helpers
	function automatic pixel_t expected_pixel(frame_t frame, int line, int step_shift);
		phase_t phase;
		phase_t inc;
		int     period;
		if (int'(frame) >= FRINGE_FRAMES) begin
			phase = {frame[0], 31'd0};  // flat frames carry a half turn on odd frames
		end else begin
			period = LINE_PERIOD[frame / 8];
			inc    = phase_t'(((64'd1 << 32) + 64'(period / 2)) / 64'(period));  // nearest step
			phase  = (phase_t'(frame % 8) << step_shift) + phase_t'(line) * inc;
		end
		return lut_copy[phase[31:22]];
	endfunction

	// own checks plus the bound assertions
	function automatic int total_errors();
		return errors + dut0.sva0.fail_count;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] expected);
		assert (got == expected)
		else begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished, %0d errors", name, total_errors() - errors_seen);
		errors_seen = total_errors();
		tests++;
	endtask

	task automatic finish_run(input bit timed_out);
		$display("tests run %0d, errors %0d", tests, total_errors());
		if (total_errors() == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	task automatic wait_frame_change();
		frame_t start;
		start = frame_index;
		while (frame_index == start)
			@(negedge CLK_50M);
	endtask

	// pixels and strobes sampled mid cycle against the output row and column
	always @(negedge CLK_50M) begin
		if (check_pixels) begin
			check_value("video.vsync", 8'(video.vsync), 8'(row == 0));
			check_value("video.de", 8'(video.de), 8'(row >= V_BLANK && col < H_ACTIVE));
		end
		if (check_pixels && video.de) begin
			check_value("pixel_1", pixel_1, expected_pixel(frame_index, row - V_BLANK, 29));
			check_value("pixel_2", pixel_2, expected_pixel(frame_index, row - V_BLANK, 30));
		end
		col = video.line_end ? 0 : col + 1;
		if (video.line_end)
			row = video.frame_end ? 0 : row + 1;
	end

	//////////////////////////////
	// stimulus
	initial begin
		reset     = 1'b1;
		rx_byte   = '0;
		rx_strobe = 1'b0;
		sync_in_1 = 1'b1;
		sync_in_2 = 1'b0;  // frames hold during the load
		repeat (8) @(negedge CLK_50M);
		reset = 1'b0;
		for (int i = 0; i < LOAD_BYTES; i++) begin
			@(negedge CLK_50M);
			rx_byte   = pixel_t'($random(seed));
			rx_strobe = 1'b1;
			if (i < 1024)
				lut_copy[i] = rx_byte;
		end
		@(negedge CLK_50M);
		rx_strobe = 1'b0;
		@(negedge CLK_50M);
		check_value("led", led, lut_copy[1023]);  // late bytes must not land
		report_test("lut_load");
		sync_in_2 = 1'b1;
		wait_frame_change();
		check_value("frame_index", 8'(frame_index), 8'd0);
		check_pixels = 1'b1;
		while (frame_index != frame_t'(FRAME_COUNT - 1))
			wait_frame_change();
		wait_frame_change();
		check_value("frame_index", 8'(frame_index), 8'd0);  // wrap
		report_test("frame_sequence");
		report_test("pixel_values");
		sync_in_2 = 1'b0;  // miss one frame end so the start delay runs again
		do
			@(negedge CLK_50M);
		while (!video.frame_end);
		sync_in_2 = 1'b1;
		repeat (3) wait_frame_change();
		report_test("sync_outputs");
		check_pixels = 1'b0;  // phase config lags until the next advance
		sync_in_1    = 1'b0;
		repeat (2) @(negedge CLK_50M);
		check_value("frame_index", 8'(frame_index), 8'(FRAME_COUNT - 1));
		sync_in_1 = 1'b1;
		wait_frame_change();
		check_value("frame_index", 8'(frame_index), 8'd0);
		check_pixels = 1'b1;
		while (frame_index != frame_t'(FRAME_COUNT - 1))
			wait_frame_change();
		wait_frame_change();  // through the flat frames
		report_test("sequencer_reset");
		finish_run(1'b0);
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
		finish_run(1'b1);
	end

endmodule

//--- all.f
design/pattern_pkg.sv
design/video_timing.sv
design/frame_sequencer.sv
design/phase_planner.sv
design/phase_accumulator.sv
design/fringe_lut.sv
design/pattern_top.sv
sim/pattern_sva.sv
sim/tb_pattern.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pattern -f all.f > sim.log 2>&1 &&
	./obj_dir/Vtb_pattern >> sim.log 2>&1 ||
	echo "build or run stopped with an error" >> sim.log
grep -qx "Simulation PASSED" sim.log && echo "run ok" || { echo "run failed, see sim.log"; exit 1; }
